// File: common/fifo_if.sv
// Push/pop FIFO connection
// Count width follows MRS_TXN_DEPTH, so the FIFO behind it must use that depth

`include "mrs_macros.svh"

interface fifo_if #(
    parameter type elem_t = logic
) ();

    // Write side
    logic  push;
    elem_t wdata;
    logic  full;

    // Read side, rdata is the head entry while not empty
    logic  pop;
    elem_t rdata;
    logic  empty;

    // Current occupancy
    logic [$clog2(`MRS_TXN_DEPTH + 1)-1:0] count;

    // Side that holds the storage
    modport owner (
        input  push, wdata, pop,
        output full, rdata, empty, count
    );

    // Side that pushes and/or pops
    // A module drives only the controls it needs
    modport user (
        output push, wdata, pop,
        input  full, rdata, empty, count
    );

endinterface

// File: common/mem_pkg.sv
// Memory port word types for the SRAM style read interface
// Address and data are one word each, read side only

`include "mrs_macros.svh"

package mem_pkg;

    // Word address sent with mem_req_o
    typedef logic [`MRS_ADDR_WIDTH-1:0] mem_addr_t;

    // Word returned with mem_rvalid_i
    typedef logic [`MRS_DATA_WIDTH-1:0] mem_data_t;

endpackage

// File: common/mrs_macros.svh
// Depth and width settings for the memory read stage
// FIFO pointer logic assumes MRS_TXN_DEPTH is at least 2
`ifndef MRS_MACROS_SVH
`define MRS_MACROS_SVH

// Transactions allowed inside the stage at once
`define MRS_TXN_DEPTH 4

// Memory port address width
`define MRS_ADDR_WIDTH 32

// Memory read word and entry word width
`define MRS_DATA_WIDTH 32

// Walker transaction id width
`define MRS_ID_WIDTH 4

`endif

// File: common/txn_pkg.sv
// Walker transaction types
// The entry word is a pointer before the memory access, table entry data after it
// Pointer and entry views must have the same width

`include "mrs_macros.svh"

package txn_pkg;

    ////////////////////////////////
    // Entry word
    ////////////////////////////////

    // One word, decoded by where the transaction is in the stage
    typedef union packed {
        mem_pkg::mem_addr_t ptr;
        mem_pkg::mem_data_t pte;
    } entry_word_u;

    // Walk flag, SKIP moves through without a memory access
    typedef enum logic {
        WALK_SKIP = 1'b0,
        WALK_DO   = 1'b1
    } walk_e;

    ////////////////////////////////
    // Transaction
    ////////////////////////////////

    // Id, walk flag and entry word
    typedef struct packed {
        logic [`MRS_ID_WIDTH-1:0] id;
        walk_e                    walk;
        entry_word_u              word;
    } txn_t;

endpackage

// File: hw/issue/grant_issue.sv
// Input hold register, credit counter and request/grant FSM
// One transaction is held at a time, the pending queue is never pushed while full
// Credits return only on output transfers

`include "mrs_macros.svh"

module grant_issue
    import txn_pkg::*;
    import mem_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_ni,

    // Walker input
    input  logic      in_valid_i,
    input  txn_t      in_txn_i,
    output logic      in_ready_o,

    // Memory request side
    output logic      mem_req_o,
    output mem_addr_t mem_addr_o,
    input  logic      mem_gnt_i,

    // Output transfer, returns one credit
    input  logic      out_fire_i,

    // Pending queue write side
    fifo_if.user      pend
);

    localparam int CRED_W = $clog2(`MRS_TXN_DEPTH + 1);
    localparam logic [CRED_W-1:0] CRED_MAX = CRED_W'(`MRS_TXN_DEPTH);

    typedef enum logic {
        ST_IDLE,
        ST_REQ
    } state_e;

    state_e            state_q;
    state_e            state_d;
    logic              hold_valid_q;
    txn_t              hold_txn_q;
    logic [CRED_W-1:0] cred_used_q;
    logic              cred_free;
    logic              hold_walk;
    logic              in_fire;
    logic              push;

    ////////////////////////////////
    // Hold register
    ////////////////////////////////

    // Ready whenever the hold slot is empty
    assign in_ready_o = !hold_valid_q;
    assign in_fire    = in_valid_i && in_ready_o;
    assign hold_walk  = (hold_txn_q.walk == WALK_DO);

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            hold_valid_q <= 1'b0;
        end else if (in_fire) begin
            hold_valid_q <= 1'b1;
        end else if (push) begin
            hold_valid_q <= 1'b0;
        end
    end

    // Payload only
    always_ff @(posedge clk_i) begin
        if (in_fire) begin
            hold_txn_q <= in_txn_i;
        end
    end

    ////////////////////////////////
    // Credits
    ////////////////////////////////

    // Counts transactions between pending push and output transfer
    assign cred_free = (cred_used_q < CRED_MAX);

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            cred_used_q <= '0;
        end else if (push && !out_fire_i) begin
            cred_used_q <= cred_used_q + 1'b1;
        end else if (out_fire_i && !push) begin
            cred_used_q <= cred_used_q - 1'b1;
        end
    end

    ////////////////////////////////
    // Request/grant FSM
    ////////////////////////////////

    always_comb begin
        state_d   = state_q;
        mem_req_o = 1'b0;
        push      = 1'b0;
        unique case (state_q)
            ST_IDLE: begin
                // Nothing issued until a credit backs the push
                if (hold_valid_q && cred_free) begin
                    if (hold_walk) begin
                        mem_req_o = 1'b1;
                        // Grant may already be high
                        if (mem_gnt_i) begin
                            push = 1'b1;
                        end else begin
                            state_d = ST_REQ;
                        end
                    end else begin
                        // Skip goes straight to pending
                        push = 1'b1;
                    end
                end
            end
            ST_REQ: begin
                // Credit is still free here, only returns can happen
                mem_req_o = 1'b1;
                if (mem_gnt_i) begin
                    push    = 1'b1;
                    state_d = ST_IDLE;
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Held word read as pointer, stable until grant
    assign mem_addr_o = hold_txn_q.word.ptr;

    // Pending queue push
    assign pend.push  = push;
    assign pend.wdata = hold_txn_q;

endmodule

// File: hw/mem_read_stage.sv
// Memory read stage for the page-table walker
// Read-only SRAM port, responses must come back in grant order, one rvalid each
// Outputs keep input order, skip transactions never touch memory

`include "mrs_macros.svh"

module mem_read_stage
    import txn_pkg::*;
(
    input  logic                       clk_i,
    input  logic                       rst_ni,

    // Walker input
    input  logic                       in_valid_i,
    output logic                       in_ready_o,
    input  logic [`MRS_ID_WIDTH-1:0]   in_id_i,
    input  logic                       in_walk_i,
    input  logic [`MRS_DATA_WIDTH-1:0] in_word_i,

    // Walker output
    output logic                       out_valid_o,
    input  logic                       out_ready_i,
    output logic [`MRS_ID_WIDTH-1:0]   out_id_o,
    output logic                       out_walk_o,
    output logic [`MRS_DATA_WIDTH-1:0] out_word_o,

    // SRAM read port
    output logic                       mem_req_o,
    output logic [`MRS_ADDR_WIDTH-1:0] mem_addr_o,
    input  logic                       mem_gnt_i,
    input  logic                       mem_rvalid_i,
    input  logic [`MRS_DATA_WIDTH-1:0] mem_rdata_i
);

    txn_t in_txn;
    txn_t out_txn;
    logic out_fire;

    // Granted and skip transactions in order
    fifo_if #(.elem_t(txn_t)) pend_if ();

    // Input word enters as a pointer
    assign in_txn.id       = in_id_i;
    assign in_txn.walk     = walk_e'(in_walk_i);
    assign in_txn.word.ptr = in_word_i;

    // Output word leaves as entry data
    assign out_id_o   = out_txn.id;
    assign out_walk_o = out_txn.walk;
    assign out_word_o = out_txn.word.pte;

    grant_issue u_grant_issue (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .in_valid_i (in_valid_i),
        .in_txn_i   (in_txn),
        .in_ready_o (in_ready_o),
        .mem_req_o  (mem_req_o),
        .mem_addr_o (mem_addr_o),
        .mem_gnt_i  (mem_gnt_i),
        .out_fire_i (out_fire),
        .pend       (pend_if)
    );

    sync_fifo #(
        .DEPTH  (`MRS_TXN_DEPTH),
        .elem_t (txn_t)
    ) pend_fifo (
        .clk_i  (clk_i),
        .rst_ni (rst_ni),
        .q      (pend_if)
    );

    response_merge u_response_merge (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .mem_rvalid_i (mem_rvalid_i),
        .mem_rdata_i  (mem_rdata_i),
        .out_valid_o  (out_valid_o),
        .out_ready_i  (out_ready_i),
        .out_txn_o    (out_txn),
        .out_fire_o   (out_fire),
        .pend         (pend_if)
    );

endmodule

// File: hw/merge/response_merge.sv
// Response capture, in-order merge and output queue
// Every rvalid is captured, so rdata must follow grant order
// Credits upstream keep both queues from overflowing

`include "mrs_macros.svh"

module response_merge
    import txn_pkg::*;
    import mem_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_ni,

    // Memory response
    input  logic      mem_rvalid_i,
    input  mem_data_t mem_rdata_i,

    // Walker output
    output logic      out_valid_o,
    input  logic      out_ready_i,
    output txn_t      out_txn_o,
    output logic      out_fire_o,

    // Pending queue read side
    fifo_if.user      pend
);

    fifo_if #(.elem_t(mem_data_t)) rsp_if ();
    fifo_if #(.elem_t(txn_t))      outq_if ();

    logic head_walk;
    logic move;
    txn_t merged;

    ////////////////////////////////
    // Response queue
    ////////////////////////////////

    // Captured in its own cycle, whatever the pending state
    assign rsp_if.push  = mem_rvalid_i;
    assign rsp_if.wdata = mem_rdata_i;

    sync_fifo #(
        .DEPTH  (`MRS_TXN_DEPTH),
        .elem_t (mem_data_t)
    ) rsp_fifo (
        .clk_i  (clk_i),
        .rst_ni (rst_ni),
        .q      (rsp_if)
    );

    ////////////////////////////////
    // In-order merge
    ////////////////////////////////

    assign head_walk = (pend.rdata.walk == WALK_DO);

    // Walk head needs its response, skip head moves alone
    // Blocked while the output queue is full
    assign move = !pend.empty && !outq_if.full && (!head_walk || !rsp_if.empty);

    always_comb begin
        merged = pend.rdata;
        // Oldest response belongs to the oldest walk
        if (head_walk) begin
            merged.word.pte = rsp_if.rdata;
        end
    end

    assign pend.pop   = move;
    assign rsp_if.pop = move && head_walk;

    ////////////////////////////////
    // Output queue
    ////////////////////////////////

    assign outq_if.push  = move;
    assign outq_if.wdata = merged;

    sync_fifo #(
        .DEPTH  (`MRS_TXN_DEPTH),
        .elem_t (txn_t)
    ) out_fifo (
        .clk_i  (clk_i),
        .rst_ni (rst_ni),
        .q      (outq_if)
    );

    // Head of the queue stays put until taken
    assign out_valid_o  = (outq_if.count != '0);
    assign out_txn_o    = outq_if.rdata;
    assign out_fire_o   = out_valid_o && out_ready_i;
    assign outq_if.pop  = out_fire_o;

endmodule

// File: hw/sync_fifo.sv
// Synchronous circular FIFO without fall-through
// A push shows at rdata and empty one cycle later
// Pushes while full and pops while empty are dropped
// DEPTH must equal MRS_TXN_DEPTH to match the interface count width

`include "mrs_macros.svh"

module sync_fifo #(
    parameter int  DEPTH  = `MRS_TXN_DEPTH,
    parameter type elem_t = logic
) (
    input  logic  clk_i,
    input  logic  rst_ni,
    fifo_if.owner q
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    // Storage, no reset needed
    elem_t mem_q [DEPTH];

    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             do_push;
    logic             do_pop;

    // Pointer advance with wrap at DEPTH
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        logic [PTR_W-1:0] nxt;
        if (ptr == PTR_W'(DEPTH - 1)) begin
            nxt = '0;
        end else begin
            nxt = ptr + 1'b1;
        end
        return nxt;
    endfunction

    // Status from the occupancy count
    assign q.full  = (count_q == CNT_W'(DEPTH));
    assign q.empty = (count_q == '0);
    assign q.count = count_q;

    // Head entry, never bypassed from wdata
    assign q.rdata = mem_q[rd_ptr_q];

    // Accepted operations only
    assign do_push = q.push && !q.full;
    assign do_pop  = q.pop && !q.empty;

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= q.wdata;
        end
    end

    // Pointers and count
    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= ptr_next(wr_ptr_q);
            end
            if (do_pop) begin
                rd_ptr_q <= ptr_next(rd_ptr_q);
            end
            // Push and pop together keep the count
            if (do_push && !do_pop) begin
                count_q <= count_q + 1'b1;
            end else if (do_pop && !do_push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

endmodule

// File: run.sh
#!/usr/bin/env bash
# Build and run the memory read stage testbench with Verilator
# Pass is decided by the pass message in the simulation log

set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -f tb.f --top-module tb_mem_read_stage \
    -Mdir "$BUILD_DIR" -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/sim_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "All checks passed" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// File: tb.f
+incdir+common
common/mem_pkg.sv
common/txn_pkg.sv
common/fifo_if.sv
hw/sync_fifo.sv
hw/issue/grant_issue.sv
hw/merge/response_merge.sv
hw/mem_read_stage.sv
tb/mrs_asserts.sv
tb/tb_mem_read_stage.sv

// File: tb/mrs_asserts.sv
// Concurrent checks on the top-level ports of the memory read stage
// Covers request and output stability and the first cycle after reset
// Data values are left to the testbench

`include "mrs_macros.svh"

module mrs_asserts (
    input logic                       clk_i,
    input logic                       rst_ni,
    input logic                       mem_req_o,
    input logic [`MRS_ADDR_WIDTH-1:0] mem_addr_o,
    input logic                       mem_gnt_i,
    input logic                       out_valid_o,
    input logic                       out_ready_i,
    input logic [`MRS_ID_WIDTH-1:0]   out_id_o,
    input logic                       out_walk_o,
    input logic [`MRS_DATA_WIDTH-1:0] out_word_o
);

    // Number of failed assertions
    int fail_cnt = 0;

    // Request held with the same address until granted
    addr_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (mem_req_o && !mem_gnt_i) |=> (mem_req_o && $stable(mem_addr_o)))
        else begin
            $error("mem_addr_o changed or mem_req_o dropped before its grant");
            fail_cnt++;
        end

    // Output held while stalled
    out_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (out_valid_o && !out_ready_i) |=>
        (out_valid_o && $stable({out_id_o, out_walk_o, out_word_o})))
        else begin
            $error("Output changed or out_valid_o dropped while stalled");
            fail_cnt++;
        end

    // First cycle out of reset is quiet
    reset_quiet: assert property (@(posedge clk_i)
        $rose(rst_ni) |-> (!mem_req_o && !out_valid_o))
        else begin
            $error("mem_req_o or out_valid_o high right after reset");
            fail_cnt++;
        end

endmodule

// File: tb/mrs_trace.txt
// Columns: id  walk(1=walk 0=skip)  input word  expected output word
// Walk lines expect memory[ptr] = ptr ^ dead0000, skip lines expect the input word
0 1 00001000 dead1000
1 0 cafe0001 cafe0001
2 1 00002040 dead2040
3 1 12345678 cc995678
4 0 0badf00d 0badf00d
5 0 00000005 00000005
6 1 8000fffc 5eadfffc
7 1 00003000 dead3000
8 0 ffffffff ffffffff
9 1 deadbeef 0000beef
a 1 00004004 dead4004
b 0 11111111 11111111
c 1 a5a5a5a5 7b08a5a5
d 0 00000000 00000000
e 1 00005008 dead5008
f 1 00006010 dead6010
0 0 76543210 76543210
1 1 ffff0000 21520000
2 1 0000abcd deadabcd
3 0 abcdef01 abcdef01

// File: tb/tb_mem_read_stage.sv
// Testbench for the memory read stage
// Paths are relative to the project root
// Stimulus and expected words come from tb/mrs_trace.txt
// Memory model answers ptr ^ dead0000 in grant order 1 to 4 cycles after each grant

`include "mrs_macros.svh"

module tb_mem_read_stage;

    localparam int          MAX_TXN     = 32;
    localparam int          IN_LIMIT    = 200;
    localparam int          DRAIN_LIMIT = 400;
    localparam logic [31:0] SEED        = 32'hce2b_7899;
    localparam logic [31:0] MEM_KEY     = 32'hdead_0000;

    logic                       clk_i;
    logic                       rst_ni;
    logic                       in_valid_i;
    logic                       in_ready_o;
    logic [`MRS_ID_WIDTH-1:0]   in_id_i;
    logic                       in_walk_i;
    logic [`MRS_DATA_WIDTH-1:0] in_word_i;
    logic                       out_valid_o;
    logic                       out_ready_i;
    logic [`MRS_ID_WIDTH-1:0]   out_id_o;
    logic                       out_walk_o;
    logic [`MRS_DATA_WIDTH-1:0] out_word_o;
    logic                       mem_req_o;
    logic [`MRS_ADDR_WIDTH-1:0] mem_addr_o;
    logic                       mem_gnt_i;
    logic                       mem_rvalid_i;
    logic [`MRS_DATA_WIDTH-1:0] mem_rdata_i;

    // Four words per trace line with id, walk, word and expected word
    logic [31:0] trace_mem [4*MAX_TXN];
    logic [31:0] walk_ptr_q [$];
    int          n_txn       = 0;
    int          n_walk      = 0;
    int          out_cnt     = 0;
    int          grant_cnt   = 0;
    int          error_cnt   = 0;
    int          timeout_cnt = 0;

    mem_read_stage UUT (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .in_valid_i   (in_valid_i),
        .in_ready_o   (in_ready_o),
        .in_id_i      (in_id_i),
        .in_walk_i    (in_walk_i),
        .in_word_i    (in_word_i),
        .out_valid_o  (out_valid_o),
        .out_ready_i  (out_ready_i),
        .out_id_o     (out_id_o),
        .out_walk_o   (out_walk_o),
        .out_word_o   (out_word_o),
        .mem_req_o    (mem_req_o),
        .mem_addr_o   (mem_addr_o),
        .mem_gnt_i    (mem_gnt_i),
        .mem_rvalid_i (mem_rvalid_i),
        .mem_rdata_i  (mem_rdata_i)
    );

    bind mem_read_stage mrs_asserts u_mrs_asserts (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .mem_req_o   (mem_req_o),
        .mem_addr_o  (mem_addr_o),
        .mem_gnt_i   (mem_gnt_i),
        .out_valid_o (out_valid_o),
        .out_ready_i (out_ready_i),
        .out_id_o    (out_id_o),
        .out_walk_o  (out_walk_o),
        .out_word_o  (out_word_o)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (act !== exp) begin
            $display("[ERROR] %s expected %h actual %h", name, exp, act);
            error_cnt++;
        end
    endtask

    // Reads the trace and cross-checks its expected words against the memory rule
    task automatic load_trace();
        int          i;
        logic [31:0] rule;
        for (i = 0; i < 4*MAX_TXN; i++) begin
            trace_mem[i] = '1;
        end
        $readmemh("tb/mrs_trace.txt", trace_mem);
        while (n_txn < MAX_TXN && trace_mem[4*n_txn] != 32'hffff_ffff) begin
            if (trace_mem[4*n_txn+1][0]) begin
                rule = trace_mem[4*n_txn+2] ^ MEM_KEY;
                walk_ptr_q.push_back(trace_mem[4*n_txn+2]);
                n_walk++;
            end else begin
                rule = trace_mem[4*n_txn+2];
            end
            if (trace_mem[4*n_txn+3] != rule) begin
                $display("Trace line %0d has an expected word that breaks the memory rule", n_txn);
                error_cnt++;
            end
            n_txn++;
        end
        if (n_txn == 0) begin
            $display("Trace file holds no transactions");
            error_cnt++;
        end
    endtask

    initial begin : clock_gen
        clk_i = 1'b0;
        forever begin
            #4 clk_i = ~clk_i;
        end
    end

    //////////////////////////////
    // Memory model
    //////////////////////////////

    initial begin : memory_model
        logic [31:0] rng_mem;
        logic [31:0] exp_addr;
        logic [31:0] rsp_data_q [$];
        int          rsp_due_q [$];
        int          cycle_cnt;
        int          due;
        int          last_due;
        rng_mem      = SEED;
        cycle_cnt    = 0;
        last_due     = 0;
        mem_gnt_i    = 1'b0;
        mem_rvalid_i = 1'b0;
        mem_rdata_i  = '0;
        forever begin
            @(negedge clk_i);
            if (rst_ni) begin
                cycle_cnt++;
                // At most one response per cycle with the oldest first
                if (rsp_due_q.size() != 0 && rsp_due_q[0] <= cycle_cnt) begin
                    mem_rvalid_i = 1'b1;
                    mem_rdata_i  = rsp_data_q.pop_front();
                    void'(rsp_due_q.pop_front());
                end else begin
                    mem_rvalid_i = 1'b0;
                    mem_rdata_i  = '0;
                end
                rng_mem   = xorshift32(rng_mem);
                mem_gnt_i = (rng_mem[1:0] != 2'd0);
                // Grant lands on the next rising edge
                if (mem_req_o && mem_gnt_i) begin
                    grant_cnt++;
                    if (walk_ptr_q.size() == 0) begin
                        $display("Memory request granted with no walk transaction left");
                        error_cnt++;
                    end else begin
                        exp_addr = walk_ptr_q.pop_front();
                        check_value("mem_addr_o", exp_addr, mem_addr_o);
                    end
                    due = cycle_cnt + 1 + int'(rng_mem[5:4]);
                    if (due <= last_due) begin
                        due = last_due + 1;
                    end
                    last_due = due;
                    rsp_due_q.push_back(due);
                    rsp_data_q.push_back(mem_addr_o ^ MEM_KEY);
                end
            end
        end
    end

    //////////////////////////////
    // Output side
    //////////////////////////////

    initial begin : output_side
        logic [31:0]                rng_out;
        logic                       held;
        logic [`MRS_ID_WIDTH-1:0]   held_id;
        logic                       held_walk;
        logic [`MRS_DATA_WIDTH-1:0] held_word;
        int                         base;
        rng_out     = xorshift32(SEED);
        held        = 1'b0;
        held_id     = '0;
        held_walk   = 1'b0;
        held_word   = '0;
        out_ready_i = 1'b0;
        forever begin
            @(negedge clk_i);
            if (rst_ni) begin
                rng_out     = xorshift32(rng_out);
                out_ready_i = (rng_out[1:0] != 2'd0);
                if (out_valid_o) begin
                    if (held) begin
                        check_value("out_id_o (held)", 32'(held_id), 32'(out_id_o));
                        check_value("out_walk_o (held)", 32'(held_walk), 32'(out_walk_o));
                        check_value("out_word_o (held)", held_word, out_word_o);
                    end
                    if (out_ready_i) begin
                        if (out_cnt >= n_txn) begin
                            $display("Output transfer with no transaction left in the trace");
                            error_cnt++;
                        end else begin
                            base = 4*out_cnt;
                            check_value("out_id_o", trace_mem[base], 32'(out_id_o));
                            check_value("out_walk_o", trace_mem[base+1], 32'(out_walk_o));
                            check_value("out_word_o", trace_mem[base+3], out_word_o);
                        end
                        out_cnt++;
                        held = 1'b0;
                    end else begin
                        held      = 1'b1;
                        held_id   = out_id_o;
                        held_walk = out_walk_o;
                        held_word = out_word_o;
                    end
                end else if (held) begin
                    $display("out_valid_o dropped before its transfer");
                    error_cnt++;
                    held = 1'b0;
                end
            end
        end
    end

    //////////////////////////////
    // Input side and run control
    //////////////////////////////

    initial begin : main
        logic [31:0] rng_in;
        logic        timed_out;
        int          idx;
        int          base;
        int          gap;
        int          waited;
        int          assert_cnt;
        rng_in     = xorshift32(xorshift32(SEED));
        timed_out  = 1'b0;
        rst_ni     = 1'b0;
        in_valid_i = 1'b0;
        in_id_i    = '0;
        in_walk_i  = 1'b0;
        in_word_i  = '0;
        load_trace();

        repeat (2) @(negedge clk_i);
        // Memory and output models still see reset at this edge
        rst_ni <= 1'b1;
        check_value("in_ready_o", 32'd1, 32'(in_ready_o));
        check_value("mem_req_o", 32'd0, 32'(mem_req_o));
        check_value("out_valid_o", 32'd0, 32'(out_valid_o));

        for (idx = 0; idx < n_txn && !timed_out; idx++) begin
            rng_in = xorshift32(rng_in);
            gap    = int'(rng_in[1:0]);
            if (gap == 3) begin
                gap = 0;
            end
            repeat (gap) @(negedge clk_i);
            base       = 4*idx;
            in_valid_i = 1'b1;
            in_id_i    = trace_mem[base][`MRS_ID_WIDTH-1:0];
            in_walk_i  = trace_mem[base+1][0];
            in_word_i  = trace_mem[base+2];
            // Ready seen here means the transfer happens on the next rising edge
            waited = 0;
            while (in_ready_o !== 1'b1 && waited < IN_LIMIT) begin
                @(negedge clk_i);
                waited++;
            end
            if (in_ready_o !== 1'b1) begin
                $display("Timeout waiting for in_ready_o on trace line %0d", idx);
                timeout_cnt++;
                timed_out = 1'b1;
            end else begin
                @(negedge clk_i);
            end
            in_valid_i = 1'b0;
        end

        waited = 0;
        while (out_cnt < n_txn && waited < DRAIN_LIMIT) begin
            @(negedge clk_i);
            waited++;
        end
        if (out_cnt < n_txn) begin
            $display("Timeout waiting for outputs, %0d of %0d received", out_cnt, n_txn);
            timeout_cnt++;
        end

        // Idle time to catch extra outputs or grants
        repeat (10) @(negedge clk_i);
        check_value("grant count", 32'(n_walk), 32'(grant_cnt));
        check_value("output count", 32'(n_txn), 32'(out_cnt));
        assert_cnt = UUT.u_mrs_asserts.fail_cnt;

        $display("Errors: %0d check, %0d assertion, %0d timeout", error_cnt, assert_cnt,
                 timeout_cnt);
        if (error_cnt == 0 && assert_cnt == 0 && timeout_cnt == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
